/* common/pf_config.svh */
// Width, field position and code macros for the dispatch slice
//   Microword fields, VMA flag bits, page flag bits

`ifndef PF_CONFIG_SVH
`define PF_CONFIG_SVH

// Bus and register widths
`define PF_UWORD_W       24
`define PF_VMA_W         36
`define PF_PAGE_W        4
`define PF_PAGE_NUM      (1 << `PF_PAGE_W)
`define PF_FLAG_W        4
`define PF_WB_ADDR_W     4
`define PF_WB_DATA_W     8

// Microword fields
`define PF_UADDR_HI      23
`define PF_UADDR_LO      12
`define PF_MEMCYC_BIT    11
`define PF_MEMWAIT_BIT   10
`define PF_CYCTYPE_HI    9
`define PF_CYCTYPE_LO    8
`define PF_SPEC_HI       7
`define PF_SPEC_LO       4
`define PF_SPECEN_BIT    3

// Special micro-addresses and spec codes
`define PF_FETCH_ADDR    12'o0110
`define PF_SPEC_MEMCLR   4'd5

// VMA flags; page index sits just above a 512-word offset
`define PF_VMA_USER_BIT   35
`define PF_VMA_WRTEST_BIT 33
`define PF_VMA_PHYS_BIT   27
`define PF_VMA_ACREF_BIT  26
`define PF_PAGE_LO        9

// Page flag bits
`define PF_FLAG_VALID_BIT 3
`define PF_FLAG_WRITE_BIT 2
`define PF_FLAG_USER_BIT  1

`endif

/* common/pfPkg.sv */
// Shared types for the page-fail dispatch slice
//   Vector typedefs for microword, VMA, page index and flags
//   Wishbone port types, cycle type and dispatch code enums

`include "pf_config.svh"

package pfPkg;

   //////////////////////////////////////////////////////////////////////
   // Plain vector types
   //////////////////////////////////////////////////////////////////////

   // One micro-instruction
   typedef logic [`PF_UWORD_W-1:0]   uword_t;

   // VMA register contents
   typedef logic [`PF_VMA_W-1:0]     vma_t;

   // Page table index
   typedef logic [`PF_PAGE_W-1:0]    pageIdx_t;

   // Valid, writeable, user, cache (msb first)
   typedef logic [`PF_FLAG_W-1:0]    pageFlags_t;

   // Host port
   typedef logic [`PF_WB_ADDR_W-1:0] wbAddr_t;
   typedef logic [`PF_WB_DATA_W-1:0] wbData_t;

   //////////////////////////////////////////////////////////////////////
   // Enumerations
   //////////////////////////////////////////////////////////////////////

   // Bus cycle type carried by the microword
   typedef enum logic [1:0] {
      CYC_NONE   = 2'd0,
      CYC_READ   = 2'd1,
      CYC_WRTEST = 2'd2,
      CYC_WRITE  = 2'd3
   } cycleType_t;

   // Page-fail dispatch codes, values follow the microcode table
   typedef enum logic [3:0] {
      DISP_NONE       = 4'd0,
      DISP_INTR       = 4'd1,
      DISP_NXM        = 4'd5,
      DISP_WRITEFAIL  = 4'd8,
      DISP_TIMPAGFAIL = 4'd9,
      DISP_INVALID    = 4'd10,
      DISP_MISMATCH   = 4'd11
   } pfDisp_t;

endpackage

/* src/uwordDecode.sv */
// Microword decoder
//   Memory-cycle, instruction-fetch and memory-clear strobes

`timescale 1ns/100ps

`include "pf_config.svh"

module uwordDecode
(
   input  pfPkg::uword_t uword,
   output logic          memCycle,
   output logic          fetchCycle,
   output logic          memClr
);

   //////////////////////////////////////////////////////////////////////
   // Field extraction
   //////////////////////////////////////////////////////////////////////

   // Micro-address of this instruction
   logic [`PF_UADDR_HI-`PF_UADDR_LO:0] uAddr;

   // Memory control bits
   logic memCycBit;
   logic memWaitBit;

   // Cycle type carried directly, no dispatch ROM
   pfPkg::cycleType_t cycType;

   // Special function select
   logic [`PF_SPEC_HI-`PF_SPEC_LO:0] specSel;
   logic                             specEn;

   assign uAddr      = uword[`PF_UADDR_HI:`PF_UADDR_LO];
   assign memCycBit  = uword[`PF_MEMCYC_BIT];
   assign memWaitBit = uword[`PF_MEMWAIT_BIT];
   assign cycType    = pfPkg::cycleType_t'(uword[`PF_CYCTYPE_HI:`PF_CYCTYPE_LO]);
   assign specSel    = uword[`PF_SPEC_HI:`PF_SPEC_LO];
   assign specEn     = uword[`PF_SPECEN_BIT];

   //////////////////////////////////////////////////////////////////////
   // Strobes
   //////////////////////////////////////////////////////////////////////

   // Memory cycle, any real cycle type counts
   // (read, write-test or write all arm the fault check)
   always_comb
   begin
      memCycle = memCycBit & memWaitBit & (cycType != pfPkg::CYC_NONE);
   end

   // Instruction fetch lives at a fixed micro-address
   assign fetchCycle = (uAddr == `PF_FETCH_ADDR);

   // Clear of the dispatch register
   assign memClr = specEn & (specSel == `PF_SPEC_MEMCLR);

endmodule

/* pager/pageTable.sv */
// Page flag table
//   Sixteen 4-bit flag entries
//   Wishbone classic slave for host load and readback
//   Combinational lookup by VMA page index

`timescale 1ns/100ps

`include "pf_config.svh"

module pageTable
(
   input  logic             clk,
   input  logic             rst,
   // Host port
   input  logic             wbCyc,
   input  logic             wbStb,
   input  logic             wbWe,
   input  pfPkg::wbAddr_t   wbAdr,
   input  pfPkg::wbData_t   wbDatW,
   output pfPkg::wbData_t   wbDatR,
   output logic             wbAck,
   // Lookup side
   input  pfPkg::vma_t      vmaReg,
   output pfPkg::pageFlags_t pageFlags
);

   //////////////////////////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////////////////////////

   // Flag entries, cleared by reset so paging starts all-invalid
   pfPkg::pageFlags_t flagMem [`PF_PAGE_NUM];

   // Host and lookup indices
   pfPkg::pageIdx_t hostIdx;
   pfPkg::pageIdx_t lookIdx;

   // New strobe seen and not yet answered
   logic wbReq;

   assign hostIdx = wbAdr[`PF_PAGE_W-1:0];
   assign lookIdx = vmaReg[`PF_PAGE_LO +: `PF_PAGE_W];
   assign wbReq   = wbCyc & wbStb & ~wbAck;

   //////////////////////////////////////////////////////////////////////
   // Wishbone acknowledge
   //////////////////////////////////////////////////////////////////////

   // Ack one cycle after the strobe, dropped on the following edge
   // so a held strobe never completes twice
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wbAck <= 1'b0;
      end
      else
      begin
         wbAck <= wbReq;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Table writes
   //////////////////////////////////////////////////////////////////////

   // Only the low flag bits of the data are kept
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         for (int i = 0; i < `PF_PAGE_NUM; i++)
         begin
            flagMem[i] <= '0;
         end
      end
      else if (wbReq & wbWe)
      begin
         flagMem[hostIdx] <= wbDatW[`PF_FLAG_W-1:0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Readback and lookup
   //////////////////////////////////////////////////////////////////////

   // Read data registered alongside the ack
   always_ff @(posedge clk)
   begin
      if (wbReq & ~wbWe)
      begin
         wbDatR <= {{(`PF_WB_DATA_W-`PF_FLAG_W){1'b0}}, flagMem[hostIdx]};
      end
   end

   // Pager side, no clock involved
   assign pageFlags = flagMem[lookIdx];

endmodule

/* src/pageFailDispatch.sv */
// Page-fail and interrupt dispatch
//   Page-fail and interrupt enable registers
//   Page condition decode and fixed priority select
//   Dispatch code register with memory-clear

`timescale 1ns/100ps

`include "pf_config.svh"

module pageFailDispatch
(
   input  logic              clk,
   input  logic              rst,
   input  logic              clkEn,
   input  logic              memCycle,
   input  logic              fetchCycle,
   input  logic              memClr,
   input  pfPkg::vma_t       vmaReg,
   input  logic              pageEnable,
   input  pfPkg::pageFlags_t pageFlags,
   input  logic              timerIntr,
   input  logic              piIntr,
   input  logic              nxmIntr,
   output logic              pageFail,
   output pfPkg::pfDisp_t    dispPf
);

   //////////////////////////////////////////////////////////////////////
   // Enables
   //////////////////////////////////////////////////////////////////////

   logic pfEn;
   logic intrEn;

   // Armed by a memory microword, always dropped on the next step
   // Back-to-back memory words therefore check only the first one
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pfEn <= 1'b0;
      end
      else if (clkEn)
      begin
         if (!pfEn)
         begin
            pfEn <= memCycle;
         end
         else
         begin
            pfEn <= 1'b0;
         end
      end
   end

   // Interrupts are only taken right after instruction fetch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         intrEn <= 1'b0;
      end
      else if (clkEn)
      begin
         intrEn <= fetchCycle;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Page conditions
   //////////////////////////////////////////////////////////////////////

   logic vmaUser;
   logic vmaPhys;
   logic vmaAcref;
   logic vmaWrtest;
   logic pageValid;
   logic pageWriteable;
   logic pageUser;
   logic pageChecked;
   logic pageInvalid;
   logic pageMismatch;
   logic pageWriteFail;

   assign vmaUser       = vmaReg[`PF_VMA_USER_BIT];
   assign vmaPhys       = vmaReg[`PF_VMA_PHYS_BIT];
   assign vmaAcref      = vmaReg[`PF_VMA_ACREF_BIT];
   assign vmaWrtest     = vmaReg[`PF_VMA_WRTEST_BIT];
   assign pageValid     = pageFlags[`PF_FLAG_VALID_BIT];
   assign pageWriteable = pageFlags[`PF_FLAG_WRITE_BIT];
   assign pageUser      = pageFlags[`PF_FLAG_USER_BIT];

   // Physical and AC references bypass the pager
   assign pageChecked   = pageEnable & ~vmaPhys & ~vmaAcref;

   assign pageInvalid   = pageChecked & ~pageValid;
   assign pageMismatch  = pageChecked & (vmaUser != pageUser);
   assign pageWriteFail = pageChecked & vmaWrtest & ~pageWriteable;

   //////////////////////////////////////////////////////////////////////
   // Priority select
   //////////////////////////////////////////////////////////////////////

   pfPkg::pfDisp_t dispNext;

   // First match wins, interrupts ahead of page faults
   always_comb
   begin
      pageFail = 1'b1;
      dispNext = pfPkg::DISP_NONE;
      if (intrEn & nxmIntr)
         dispNext = pfPkg::DISP_NXM;
      else if (intrEn & piIntr)
         dispNext = pfPkg::DISP_INTR;
      else if (intrEn & timerIntr & pageInvalid)
         dispNext = pfPkg::DISP_TIMPAGFAIL;
      else if (intrEn & timerIntr)
         dispNext = pfPkg::DISP_INTR;
      else if (pfEn & pageInvalid)
         dispNext = pfPkg::DISP_INVALID;
      else if (pfEn & pageMismatch)
         dispNext = pfPkg::DISP_MISMATCH;
      else if (pfEn & pageWriteFail)
         dispNext = pfPkg::DISP_WRITEFAIL;
      else
         pageFail = 1'b0;
   end

   //////////////////////////////////////////////////////////////////////
   // Dispatch register
   //////////////////////////////////////////////////////////////////////

   // New fault beats a clear on the same edge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dispPf <= pfPkg::DISP_NONE;
      end
      else if (clkEn)
      begin
         if (pageFail)
         begin
            dispPf <= dispNext;
         end
         else if (memClr)
         begin
            dispPf <= pfPkg::DISP_NONE;
         end
      end
   end

endmodule

/* src/pfTop.sv */
// Top level of the page-fail dispatch slice
//   Microword decoder, page table and dispatch block

`timescale 1ns/100ps

`include "pf_config.svh"

module pfTop
(
   input  logic              clk,
   input  logic              rst,
   // Microsequencer side
   input  pfPkg::uword_t     uword,
   input  logic              clkEn,
   input  pfPkg::vma_t       vmaReg,
   input  logic              pageEnable,
   input  logic              timerIntr,
   input  logic              piIntr,
   input  logic              nxmIntr,
   output logic              pageFail,
   output pfPkg::pfDisp_t    dispPf,
   // Host port
   input  logic              wbCyc,
   input  logic              wbStb,
   input  logic              wbWe,
   input  pfPkg::wbAddr_t    wbAdr,
   input  pfPkg::wbData_t    wbDatW,
   output pfPkg::wbData_t    wbDatR,
   output logic              wbAck
);

   // Decoder strobes
   logic memCycle;
   logic fetchCycle;
   logic memClr;

   // Flags of the current VMA page
   pfPkg::pageFlags_t pageFlags;

   uwordDecode uDecode
   (
      .uword      (uword),
      .memCycle   (memCycle),
      .fetchCycle (fetchCycle),
      .memClr     (memClr)
   );

   pageTable uPageTable
   (
      .clk       (clk),
      .rst       (rst),
      .wbCyc     (wbCyc),
      .wbStb     (wbStb),
      .wbWe      (wbWe),
      .wbAdr     (wbAdr),
      .wbDatW    (wbDatW),
      .wbDatR    (wbDatR),
      .wbAck     (wbAck),
      .vmaReg    (vmaReg),
      .pageFlags (pageFlags)
   );

   pageFailDispatch uDispatch
   (
      .clk        (clk),
      .rst        (rst),
      .clkEn      (clkEn),
      .memCycle   (memCycle),
      .fetchCycle (fetchCycle),
      .memClr     (memClr),
      .vmaReg     (vmaReg),
      .pageEnable (pageEnable),
      .pageFlags  (pageFlags),
      .timerIntr  (timerIntr),
      .piIntr     (piIntr),
      .nxmIntr    (nxmIntr),
      .pageFail   (pageFail),
      .dispPf     (dispPf)
   );

endmodule

/* bench/pfChecker.sv */
// Checker for the page-fail dispatch testbench
//   Samples DUT outputs at the falling edge
//   Compares against pattern values, keeps per-test and total counts

`timescale 1ns/100ps

module pfChecker
(
   input  logic           clk,
   input  logic           pageFail,
   input  pfPkg::pfDisp_t dispPf,
   input  pfPkg::wbData_t wbDatR,
   input  logic           chkPf,
   input  logic           expPf,
   input  logic           chkDisp,
   input  logic [3:0]     expDisp,
   input  logic           chkRd,
   input  pfPkg::wbData_t expRd,
   input  logic           testEnd,
   input  int             testNum,
   output int             errCount,
   output int             checkCount,
   output int             testCount
);

   int testErrs;
   int testChecks;

   initial
   begin
      errCount   = 0;
      checkCount = 0;
      testCount  = 0;
      testErrs   = 0;
      testChecks = 0;
   end

   //////////////////////////////////////////////////////////////////////
   // Comparisons, mid-cycle so inputs and outputs are settled
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      // pageFail in the cycle after the microword
      if (chkPf)
      begin
         checkCount++;
         testChecks++;
         if (pageFail !== expPf)
         begin
            errCount++;
            testErrs++;
            $display("FAILED at %0t ns: test %0d pageFail %b, expected %b",
                     $time, testNum, pageFail, expPf);
         end
      end

      // Dispatch code after the closing edge; enables must be down again
      if (chkDisp)
      begin
         checkCount++;
         testChecks++;
         if (dispPf !== expDisp)
         begin
            errCount++;
            testErrs++;
            $display("FAILED at %0t ns: test %0d dispPf %0d, expected %0d",
                     $time, testNum, dispPf, expDisp);
         end
         if (pageFail !== 1'b0)
         begin
            errCount++;
            testErrs++;
            $display("FAILED at %0t ns: test %0d pageFail held past its cycle",
                     $time, testNum);
         end
      end

      // Readback, zero-extended flags
      if (chkRd)
      begin
         checkCount++;
         testChecks++;
         if (wbDatR !== expRd)
         begin
            errCount++;
            testErrs++;
            $display("FAILED at %0t ns: test %0d read data %h, expected %h",
                     $time, testNum, wbDatR, expRd);
         end
      end

      // One line per finished test
      if (testEnd)
      begin
         testCount++;
         if (testErrs == 0)
            $display("Test %0d ok, %0d checks", testNum, testChecks);
         else
            $display("Test %0d failed, %0d of %0d checks wrong",
                     testNum, testErrs, testChecks);
         testErrs   = 0;
         testChecks = 0;
      end
   end

endmodule

/* bench/pfTb.sv */
// Testbench top for the page-fail dispatch slice
//   Clock, reset, pattern file reader
//   Wishbone load and readback tasks, microsequencer stand-in

`timescale 1ns/100ps

module pfTb;

   localparam int WB_TIMEOUT   = 20;
   localparam int IDLE_TIMEOUT = 20;

   logic              clk;
   logic              rst;
   pfPkg::uword_t     uword;
   logic              clkEn;
   pfPkg::vma_t       vmaReg;
   logic              pageEnable;
   logic              timerIntr;
   logic              piIntr;
   logic              nxmIntr;
   logic              pageFail;
   pfPkg::pfDisp_t    dispPf;
   logic              wbCyc;
   logic              wbStb;
   logic              wbWe;
   pfPkg::wbAddr_t    wbAdr;
   pfPkg::wbData_t    wbDatW;
   pfPkg::wbData_t    wbDatR;
   logic              wbAck;

   // Checker controls and expected values
   logic              chkPf;
   logic              expPf;
   logic              chkDisp;
   logic [3:0]        expDisp;
   logic              chkRd;
   pfPkg::wbData_t    expRd;
   logic              testEnd;
   int                testNum;
   int                errCount;
   int                checkCount;
   int                testCount;

   bit                timedOut;

   //////////////////////////////////////////////////////////////////////
   // DUT and checker
   //////////////////////////////////////////////////////////////////////

   pfTop DUT
   (
      .clk        (clk),
      .rst        (rst),
      .uword      (uword),
      .clkEn      (clkEn),
      .vmaReg     (vmaReg),
      .pageEnable (pageEnable),
      .timerIntr  (timerIntr),
      .piIntr     (piIntr),
      .nxmIntr    (nxmIntr),
      .pageFail   (pageFail),
      .dispPf     (dispPf),
      .wbCyc      (wbCyc),
      .wbStb      (wbStb),
      .wbWe       (wbWe),
      .wbAdr      (wbAdr),
      .wbDatW     (wbDatW),
      .wbDatR     (wbDatR),
      .wbAck      (wbAck)
   );

   pfChecker uChecker
   (
      .clk        (clk),
      .pageFail   (pageFail),
      .dispPf     (dispPf),
      .wbDatR     (wbDatR),
      .chkPf      (chkPf),
      .expPf      (expPf),
      .chkDisp    (chkDisp),
      .expDisp    (expDisp),
      .chkRd      (chkRd),
      .expRd      (expRd),
      .testEnd    (testEnd),
      .testNum    (testNum),
      .errCount   (errCount),
      .checkCount (checkCount),
      .testCount  (testCount)
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   // Inputs change 1 ns after the rising edge
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   // One classic single transfer, read data checked during the ack cycle
   task automatic wbTransfer(input logic we, input pfPkg::wbAddr_t adr,
                             input pfPkg::wbData_t dat);
      int waitCnt;
      waitCnt = 0;
      wbCyc  = 1'b1;
      wbStb  = 1'b1;
      wbWe   = we;
      wbAdr  = adr;
      wbDatW = we ? dat : '0;
      nextCycle();
      while (!wbAck && waitCnt < WB_TIMEOUT)
      begin
         nextCycle();
         waitCnt++;
      end
      if (!wbAck)
      begin
         $display("Timeout: no Wishbone ack for address %h", adr);
         timedOut = 1'b1;
      end
      else if (!we)
      begin
         chkRd = 1'b1;
         expRd = dat;
      end
      // Completion edge
      nextCycle();
      chkRd = 1'b0;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe  = 1'b0;
   endtask

   // Host port must be quiet before a step
   task automatic waitBusIdle();
      int waitCnt;
      waitCnt = 0;
      while (wbAck && waitCnt < IDLE_TIMEOUT)
      begin
         nextCycle();
         waitCnt++;
      end
      if (wbAck)
      begin
         $display("Timeout: Wishbone ack stuck high before a step");
         timedOut = 1'b1;
      end
   endtask

   // Microword, optional stall, follow-up word, then dispatch check
   task automatic runStep(input pfPkg::uword_t uw, input pfPkg::uword_t uw2,
                          input pfPkg::vma_t vma, input logic pe,
                          input logic tim, input logic pi, input logic nxm,
                          input logic stall, input logic ePf,
                          input logic [3:0] eDisp);
      int gap;
      // Cycle A, the triggering microword
      uword      = uw;
      vmaReg     = vma;
      pageEnable = pe;
      timerIntr  = tim;
      piIntr     = pi;
      nxmIntr    = nxm;
      clkEn      = 1'b1;
      nextCycle();
      // Stalled cycles hold pfEn and intrEn
      if (stall)
      begin
         clkEn = 1'b0;
         uword = uw2;
         gap   = int'($urandom_range(4, 1));
         repeat (gap) nextCycle();
      end
      // Cycle B, pageFail valid here
      uword = uw2;
      clkEn = 1'b1;
      chkPf = 1'b1;
      expPf = ePf;
      nextCycle();
      // Cycle C, dispatch register loaded, enables dropped
      uword   = '0;
      clkEn   = 1'b0;
      chkPf   = 1'b0;
      chkDisp = 1'b1;
      expDisp = eDisp;
      nextCycle();
      chkDisp    = 1'b0;
      timerIntr  = 1'b0;
      piIntr     = 1'b0;
      nxmIntr    = 1'b0;
      gap = int'($urandom_range(3, 0));
      repeat (gap) nextCycle();
   endtask

   task automatic closeTest();
      testEnd = 1'b1;
      nextCycle();
      testEnd = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      int             fd;
      int             n;
      int             t;
      int             curTest;
      string          line;
      byte            kind;
      pfPkg::uword_t  uw;
      pfPkg::uword_t  uw2;
      pfPkg::vma_t    vma;
      pfPkg::wbAddr_t adr;
      pfPkg::wbData_t dat;
      logic           pe;
      logic           tim;
      logic           pi;
      logic           nxm;
      logic           stall;
      logic           ePf;
      logic [3:0]     eDisp;

      void'($urandom(32'hc9b3227b));
      rst        = 1'b1;
      uword      = '0;
      clkEn      = 1'b0;
      vmaReg     = '0;
      pageEnable = 1'b0;
      timerIntr  = 1'b0;
      piIntr     = 1'b0;
      nxmIntr    = 1'b0;
      wbCyc      = 1'b0;
      wbStb      = 1'b0;
      wbWe       = 1'b0;
      wbAdr      = '0;
      wbDatW     = '0;
      chkPf      = 1'b0;
      expPf      = 1'b0;
      chkDisp    = 1'b0;
      expDisp    = '0;
      chkRd      = 1'b0;
      expRd      = '0;
      testEnd    = 1'b0;
      testNum    = 0;
      timedOut   = 1'b0;
      curTest    = 0;

      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      nextCycle();

      fd = $fopen("bench/pf_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the pattern file bench/pf_patterns.txt");
         timedOut = 1'b1;
      end
      else
      begin
         while (!$feof(fd) && !timedOut)
         begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0)
            begin
               kind = line[0];
               t    = curTest;
               if (kind == "W")
                  n = $sscanf(line, "W %d %h %h", t, adr, dat);
               else if (kind == "R")
                  n = $sscanf(line, "R %d %h %h", t, adr, dat);
               else if (kind == "S")
                  n = $sscanf(line, "S %d %h %h %h %d %d %d %d %d %d %d", t, uw, uw2,
                              vma, pe, tim, pi, nxm, stall, ePf, eDisp);
               // New test number closes the previous test
               if (t != curTest && (kind == "W" || kind == "R" || kind == "S"))
               begin
                  if (curTest != 0)
                     closeTest();
                  curTest = t;
                  testNum = t;
               end
               if (kind == "W")
                  wbTransfer(1'b1, adr, dat);
               else if (kind == "R")
                  wbTransfer(1'b0, adr, dat);
               else if (kind == "S")
               begin
                  waitBusIdle();
                  runStep(uw, uw2, vma, pe, tim, pi, nxm, stall, ePf, eDisp);
               end
            end
         end
         $fclose(fd);
         if (curTest != 0)
            closeTest();
      end

      $display("Tests run %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
      if (errCount == 0 && !timedOut && checkCount > 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* bench/pf_patterns.txt */
# W test addr data : Wishbone write      R test addr expected : Wishbone read
# S test uword uword2 vma pageEnable timer pi nxm stall expPageFail expDispPf(decimal)
W 1 1 FE
W 1 2 0A
W 1 3 0C
W 1 4 00
W 1 5 2F
W 1 6 03
R 1 1 0E
R 1 2 0A
R 1 3 0C
R 1 4 00
R 1 5 0F
R 1 6 03
R 1 7 00
# page faults, invalid wins when several hold
S 2 080D00 000000 800000800 1 0 0 0 0 1 10
S 2 080D00 000000 800000600 1 0 0 0 0 1 11
S 2 080E00 000000 A00000400 1 0 0 0 0 1 8
S 2 080E00 000000 200000C00 1 0 0 0 0 1 10
S 2 080E00 000000 200000400 1 0 0 0 0 1 11
S 2 080D00 000000 800000200 1 0 0 0 0 0 11
# exemptions keep the previous code
S 3 080D00 000000 808000800 1 0 0 0 0 0 11
S 3 080D00 000000 804000800 1 0 0 0 0 0 11
S 3 080D00 000000 800000800 0 0 0 0 0 0 11
S 3 080C00 000000 800000800 1 0 0 0 0 0 11
S 3 000000 000000 800000800 1 0 0 0 0 0 11
# interrupts at fetch
S 4 048000 000000 800000200 1 1 1 1 0 1 5
S 4 048000 000000 800000200 1 1 1 0 0 1 1
S 4 048000 000000 800000800 1 1 0 0 0 1 9
S 4 048000 000000 800000200 1 1 0 0 0 1 1
S 4 048000 000000 800000800 1 0 0 0 0 0 1
S 4 000000 000000 800000800 1 1 1 1 0 0 1
S 4 080D00 000000 800000200 1 1 1 1 0 0 1
# clearing
S 5 100058 000000 800000200 1 0 0 0 0 0 0
S 5 080D00 100058 800000800 1 0 0 0 0 1 10
S 5 080D58 000000 800000600 1 0 0 0 0 1 11
S 5 100058 000000 800000200 1 0 0 0 0 0 0
S 5 048000 100058 800000200 1 0 0 1 0 1 5
S 5 100058 000000 800000200 1 0 0 0 0 0 0
# stalls and back-to-back memory words
S 6 080D00 000000 800000800 1 0 0 0 1 1 10
S 6 048000 000000 800000200 1 0 0 1 1 1 5
S 6 048000 000000 800000800 1 1 0 0 1 1 9
S 6 080E00 000000 A00000400 1 0 0 0 1 1 8
S 6 100058 000000 800000200 1 0 0 0 1 0 0
S 6 080D00 080D00 800000800 1 0 0 0 1 1 10
S 6 100058 000000 800000200 1 0 0 0 0 0 0
S 6 080D00 080D00 800000800 1 0 0 0 0 1 10

/* vlog.f */
+incdir+common
common/pfPkg.sv
src/uwordDecode.sv
pager/pageTable.sv
src/pageFailDispatch.sv
src/pfTop.sv
bench/pfChecker.sv
bench/pfTb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the page-fail dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module pfTb -f vlog.f -Mdir obj_dir -o pfSim > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/pfSim > sim.log 2>&1
cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
